// File: include/bev_config.svh
`ifndef BEV_CONFIG_SVH
`define BEV_CONFIG_SVH

// ingredient amounts stored per box
`define BEV_AMOUNT_W 12

// supply saturates every ingredient at this value
`define BEV_AMOUNT_MAX 4095

// one record per box in external memory
`define BEV_BOX_AW 8

// width of one stored record
`define BEV_WORD_W 64

// volume of one recipe quarter for each cup size
// a full cup is four quarters
`define BEV_QUARTER_L 240
`define BEV_QUARTER_M 180
`define BEV_QUARTER_S 120

`endif

// File: rtl/bev_controller.sv
`default_nettype none

module bev_controller (
    input  logic                 clk,
    input  logic                 inf,
    input  logic                 cmd_valid,
    input  bev_pkg::bev_cmd_t    cmd,
    output logic                 mem_req_valid,
    output bev_pkg::mem_req_t    mem_req,
    input  logic                 mem_resp_valid,
    input  bev_pkg::box_record_t mem_resp_data,
    output logic                 out_valid,
    output bev_pkg::bev_result_t result,
    output bev_pkg::bev_cmd_t    cur_cmd,
    output bev_pkg::box_record_t cur_record,
    input  bev_pkg::box_record_t new_record,
    input  bev_pkg::err_e        eval_err
);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_wait_read,
        st_eval,
        st_write,
        st_wait_write,
        st_output
    } state_t;

    state_t state;
    state_t state_next;

    // write response seen, delayed one cycle to line up with the read path
    logic resp_q;
    logic do_write;

    bev_pkg::box_record_t wr_record;
    bev_pkg::err_e        err_q;

    // supply always stores its sums, a make only when nothing failed
    assign do_write = (cur_cmd.action == bev_pkg::act_supply) ||
                      ((cur_cmd.action == bev_pkg::act_make_drink) &&
                       (eval_err == bev_pkg::err_none));

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (cmd_valid) begin
                    state_next = st_read;
                end
            end
            st_read: begin
                state_next = st_wait_read;
            end
            st_wait_read: begin
                if (mem_resp_valid) begin
                    state_next = st_eval;
                end
            end
            st_eval: begin
                state_next = do_write ? st_write : st_output;
            end
            st_write: begin
                state_next = st_wait_write;
            end
            st_wait_write: begin
                if (resp_q) begin
                    state_next = st_output;
                end
            end
            st_output: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state  <= st_idle;
            resp_q <= 1'b0;
        end else begin
            state  <= state_next;
            resp_q <= mem_resp_valid && (state == st_wait_write);
        end
    end

    // command and record held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == st_idle && cmd_valid) begin
            cur_cmd <= cmd;
        end
        if (state == st_wait_read && mem_resp_valid) begin
            cur_record <= mem_resp_data;
        end
        // the only cycle in which the evaluator output is used
        if (state == st_eval) begin
            wr_record <= new_record;
            err_q     <= eval_err;
        end
    end

    assign mem_req_valid = (state == st_read) || (state == st_write);

    always_comb begin
        mem_req = '0;
        if (state == st_read) begin
            mem_req.addr = cur_cmd.box;
        end else if (state == st_write) begin
            mem_req.addr  = cur_cmd.box;
            mem_req.write = 1'b1;
            mem_req.data  = wr_record;
        end
    end

    assign out_valid = (state == st_output);

    always_comb begin
        result = '0;
        if (out_valid) begin
            result.err      = err_q;
            result.complete = (err_q == bev_pkg::err_none);
        end
    end

endmodule

`default_nettype wire

// File: rtl/bev_pkg.sv
`default_nettype none

`include "bev_config.svh"

package bev_pkg;

    typedef enum logic [1:0] {
        act_make_drink = 2'd0,
        act_supply     = 2'd1,
        act_check_date = 2'd2
    } action_e;

    typedef enum logic [2:0] {
        drink_black_tea          = 3'd0,
        drink_milk_tea           = 3'd1,
        drink_extra_milk_tea     = 3'd2,
        drink_green_tea          = 3'd3,
        drink_green_milk_tea     = 3'd4,
        drink_pineapple_juice    = 3'd5,
        drink_pineapple_tea      = 3'd6,
        drink_pineapple_milk_tea = 3'd7
    } drink_e;

    // code 2 is not a cup size
    typedef enum logic [1:0] {
        size_l = 2'd0,
        size_m = 2'd1,
        size_s = 2'd3
    } size_e;

    typedef enum logic [1:0] {
        err_none     = 2'd0,
        err_expired  = 2'd1,
        err_shortage = 2'd2,
        err_overflow = 2'd3
    } err_e;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } bev_date_t;

    typedef struct packed {
        logic [`BEV_AMOUNT_W-1:0] black_tea;
        logic [`BEV_AMOUNT_W-1:0] green_tea;
        logic [`BEV_AMOUNT_W-1:0] milk;
        logic [`BEV_AMOUNT_W-1:0] pineapple;
    } amounts_t;

    typedef struct packed {
        action_e                action;
        drink_e                 drink;
        size_e                  size;
        bev_date_t              date;
        logic [`BEV_BOX_AW-1:0] box;
        // delivered amounts, only used by supply
        amounts_t               supply;
    } bev_cmd_t;

    // layout of one memory word, msb first
    typedef struct packed {
        logic [`BEV_AMOUNT_W-1:0] black_tea;
        logic [`BEV_AMOUNT_W-1:0] green_tea;
        logic [7:0]               month;
        logic [`BEV_AMOUNT_W-1:0] milk;
        logic [`BEV_AMOUNT_W-1:0] pineapple;
        logic [7:0]               day;
    } box_record_t;

    typedef struct packed {
        logic [`BEV_BOX_AW-1:0] addr;
        logic                   write;
        box_record_t            data;
    } mem_req_t;

    typedef struct packed {
        err_e err;
        logic complete;
    } bev_result_t;

endpackage

`default_nettype wire

// File: rtl/bev_top.sv
`default_nettype none

module bev_top (
    input  logic                 clk,
    input  logic                 inf,
    input  logic                 cmd_valid,
    input  bev_pkg::bev_cmd_t    cmd,
    output logic                 mem_req_valid,
    output bev_pkg::mem_req_t    mem_req,
    input  logic                 mem_resp_valid,
    input  bev_pkg::box_record_t mem_resp_data,
    output logic                 out_valid,
    output bev_pkg::bev_result_t result
);

    // latched command and record from the controller
    bev_pkg::bev_cmd_t    cur_cmd;
    bev_pkg::box_record_t cur_record;

    // evaluation result back to the controller
    bev_pkg::box_record_t new_record;
    bev_pkg::err_e        eval_err;

    bev_controller u_ctrl (
        .clk            (clk),
        .inf            (inf),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .out_valid      (out_valid),
        .result         (result),
        .cur_cmd        (cur_cmd),
        .cur_record     (cur_record),
        .new_record     (new_record),
        .eval_err       (eval_err)
    );

    stock_eval u_eval (
        .cmd        (cur_cmd),
        .record     (cur_record),
        .new_record (new_record),
        .err        (eval_err)
    );

endmodule

`default_nettype wire

// File: rtl/recipe_table.sv
`default_nettype none

`include "bev_config.svh"

module recipe_table (
    input  bev_pkg::drink_e   drink,
    input  bev_pkg::size_e    size,
    output bev_pkg::amounts_t usage
);

    // number of quarters of each ingredient in the cup
    logic [2:0]               q_black;
    logic [2:0]               q_green;
    logic [2:0]               q_milk;
    logic [2:0]               q_pine;
    logic [`BEV_AMOUNT_W-1:0] quarter;

    // volume of one quarter for the cup size
    always_comb begin
        case (size)
            bev_pkg::size_l: quarter = `BEV_AMOUNT_W'(`BEV_QUARTER_L);
            bev_pkg::size_m: quarter = `BEV_AMOUNT_W'(`BEV_QUARTER_M);
            bev_pkg::size_s: quarter = `BEV_AMOUNT_W'(`BEV_QUARTER_S);
            // unused size code makes nothing
            default:         quarter = '0;
        endcase
    end

    always_comb begin
        q_black = 3'd0;
        q_green = 3'd0;
        q_milk  = 3'd0;
        q_pine  = 3'd0;
        case (drink)
            bev_pkg::drink_black_tea: begin
                q_black = 3'd4;
            end
            bev_pkg::drink_milk_tea: begin
                q_black = 3'd3;
                q_milk  = 3'd1;
            end
            bev_pkg::drink_extra_milk_tea: begin
                q_black = 3'd2;
                q_milk  = 3'd2;
            end
            bev_pkg::drink_green_tea: begin
                q_green = 3'd4;
            end
            bev_pkg::drink_green_milk_tea: begin
                q_green = 3'd2;
                q_milk  = 3'd2;
            end
            bev_pkg::drink_pineapple_juice: begin
                q_pine = 3'd4;
            end
            bev_pkg::drink_pineapple_tea: begin
                q_black = 3'd2;
                q_pine  = 3'd2;
            end
            bev_pkg::drink_pineapple_milk_tea: begin
                q_black = 3'd2;
                q_milk  = 3'd1;
                q_pine  = 3'd1;
            end
            default: begin
                q_black = 3'd0;
            end
        endcase
    end

    // at most 4 x 240, always fits the amount width
    assign usage.black_tea = `BEV_AMOUNT_W'(q_black) * quarter;
    assign usage.green_tea = `BEV_AMOUNT_W'(q_green) * quarter;
    assign usage.milk      = `BEV_AMOUNT_W'(q_milk) * quarter;
    assign usage.pineapple = `BEV_AMOUNT_W'(q_pine) * quarter;

endmodule

`default_nettype wire

// File: rtl/stock_eval.sv
`default_nettype none

`include "bev_config.svh"

module stock_eval (
    input  bev_pkg::bev_cmd_t    cmd,
    input  bev_pkg::box_record_t record,
    output bev_pkg::box_record_t new_record,
    output bev_pkg::err_e        err
);

    bev_pkg::amounts_t usage;

    // lane 3 is black tea down to lane 0 pineapple, same order as amounts_t
    logic [3:0][`BEV_AMOUNT_W-1:0] have;
    logic [3:0][`BEV_AMOUNT_W-1:0] need;
    logic [3:0][`BEV_AMOUNT_W-1:0] add;
    logic [3:0][`BEV_AMOUNT_W-1:0] left;
    logic [3:0][`BEV_AMOUNT_W-1:0] filled;

    logic expired;
    logic short;
    logic over;

    recipe_table u_recipe (
        .drink (cmd.drink),
        .size  (cmd.size),
        .usage (usage)
    );

    assign have = {record.black_tea, record.green_tea, record.milk, record.pineapple};
    assign need = usage;
    assign add  = cmd.supply;

    // order date strictly after the stored expiry date
    assign expired = ({4'b0, cmd.date.month} > record.month) ||
                     (({4'b0, cmd.date.month} == record.month) &&
                      ({3'b0, cmd.date.day} > record.day));

    always_comb begin
        logic [`BEV_AMOUNT_W:0] sum;
        short = 1'b0;
        over  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            sum       = {1'b0, have[i]} + {1'b0, add[i]};
            left[i]   = have[i] - need[i];
            short     = short | (have[i] < need[i]);
            if (sum > `BEV_AMOUNT_MAX) begin
                over      = 1'b1;
                filled[i] = `BEV_AMOUNT_W'(`BEV_AMOUNT_MAX);
            end else begin
                filled[i] = sum[`BEV_AMOUNT_W-1:0];
            end
        end
    end

    always_comb begin
        new_record = record;
        err        = bev_pkg::err_none;
        case (cmd.action)
            bev_pkg::act_make_drink: begin
                // an expired box reports expired even when stock is short too
                if (expired) begin
                    err = bev_pkg::err_expired;
                end else if (short) begin
                    err = bev_pkg::err_shortage;
                end else begin
                    new_record.black_tea = left[3];
                    new_record.green_tea = left[2];
                    new_record.milk      = left[1];
                    new_record.pineapple = left[0];
                end
            end
            bev_pkg::act_supply: begin
                if (over) begin
                    err = bev_pkg::err_overflow;
                end
                // saturated amounts are stored even on overflow
                new_record.black_tea = filled[3];
                new_record.green_tea = filled[2];
                new_record.milk      = filled[1];
                new_record.pineapple = filled[0];
                new_record.month     = {4'b0, cmd.date.month};
                new_record.day       = {3'b0, cmd.date.day};
            end
            bev_pkg::act_check_date: begin
                if (expired) begin
                    err = bev_pkg::err_expired;
                end
            end
            default: begin
                err = bev_pkg::err_none;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tb_bev \
    -f sim.f -Mdir obj_dir -o sim_bev

./obj_dir/sim_bev | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: sim.f
+incdir+include
rtl/bev_pkg.sv
rtl/recipe_table.sv
rtl/stock_eval.sv
rtl/bev_controller.sv
rtl/bev_top.sv
testbench/bev_checker.sv
testbench/tb_bev.sv

// File: testbench/bev_checker.sv
`default_nettype none

`include "bev_config.svh"

module bev_checker (
    input  logic                 clk,
    input  logic                 inf,
    input  logic                 cmd_valid,
    input  bev_pkg::bev_cmd_t    cmd,
    input  logic                 mem_req_valid,
    input  bev_pkg::mem_req_t    mem_req,
    input  logic                 mem_resp_valid,
    input  logic                 out_valid,
    input  bev_pkg::bev_result_t result,
    output int                   error_count,
    output int                   result_count
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        bev_pkg::err_e        err;
        logic                 write;
        bev_pkg::box_record_t rec;
    } expect_t;

    // shadow of every box as the memory should hold it
    bev_pkg::box_record_t   shadow [1 << `BEV_BOX_AW];
    expect_t                expected;
    logic [`BEV_BOX_AW-1:0] box_q;
    logic                   busy;
    int                     req_seen;
    int                     cycle;
    int                     last_resp;
    int                     cmd_count;
    int                     req_count;

    function automatic bev_pkg::box_record_t initial_record(input logic [`BEV_BOX_AW-1:0] a);
        bev_pkg::box_record_t w;
        int                   n;
        n           = int'(a);
        w.black_tea = `BEV_AMOUNT_W'((n * 149 + 211) % 4096);
        w.green_tea = `BEV_AMOUNT_W'((n * 83 + 1500) % 4096);
        w.milk      = `BEV_AMOUNT_W'((n * 197 + 37) % 4096);
        w.pineapple = `BEV_AMOUNT_W'((n * 59 + 2900) % 4096);
        w.month     = 8'(n % 12 + 1);
        w.day       = 8'((n * 7) % 28 + 1);
        return w;
    endfunction

    // lane 0 black tea, 1 green tea, 2 milk, 3 pineapple
    function automatic logic [`BEV_AMOUNT_W-1:0] usage_of(input bev_pkg::drink_e drink,
                                                        input bev_pkg::size_e size,
                                                        input int lane);
        logic [15:0] quarters;
        int          vol;
        // one nibble of quarters per ingredient with black tea on top
        case (drink)
            bev_pkg::drink_black_tea:          quarters = 16'h4000;
            bev_pkg::drink_milk_tea:           quarters = 16'h3010;
            bev_pkg::drink_extra_milk_tea:     quarters = 16'h2020;
            bev_pkg::drink_green_tea:          quarters = 16'h0400;
            bev_pkg::drink_green_milk_tea:     quarters = 16'h0220;
            bev_pkg::drink_pineapple_juice:    quarters = 16'h0004;
            bev_pkg::drink_pineapple_tea:      quarters = 16'h2002;
            bev_pkg::drink_pineapple_milk_tea: quarters = 16'h2011;
            default:                           quarters = 16'h0000;
        endcase
        case (size)
            bev_pkg::size_l: vol = `BEV_QUARTER_L;
            bev_pkg::size_m: vol = `BEV_QUARTER_M;
            bev_pkg::size_s: vol = `BEV_QUARTER_S;
            default:         vol = 0;
        endcase
        return `BEV_AMOUNT_W'(int'(quarters[(3 - lane) * 4 +: 4]) * vol);
    endfunction

    // expected error, write and written record for one command
    function automatic expect_t predict(input bev_pkg::bev_cmd_t c,
                                        input bev_pkg::box_record_t r);
        expect_t                  e;
        logic [`BEV_AMOUNT_W-1:0] have [4];
        logic [`BEV_AMOUNT_W-1:0] extra [4];
        logic [`BEV_AMOUNT_W-1:0] left [4];
        logic [`BEV_AMOUNT_W-1:0] sums [4];
        logic [`BEV_AMOUNT_W-1:0] amt [4];
        logic [`BEV_AMOUNT_W-1:0] need;
        int                       total;
        logic                     late;
        logic                     short_any;
        logic                     over_any;
        have  = '{r.black_tea, r.green_tea, r.milk, r.pineapple};
        extra = '{c.supply.black_tea, c.supply.green_tea, c.supply.milk, c.supply.pineapple};
        late  = (int'(c.date.month) > int'(r.month)) ||
                ((int'(c.date.month) == int'(r.month)) && (int'(c.date.day) > int'(r.day)));
        short_any = 1'b0;
        over_any  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            need      = usage_of(c.drink, c.size, i);
            short_any = short_any | (have[i] < need);
            left[i]   = have[i] - need;
            total     = int'(have[i]) + int'(extra[i]);
            over_any  = over_any | (total > `BEV_AMOUNT_MAX);
            sums[i]   = (total > `BEV_AMOUNT_MAX) ? `BEV_AMOUNT_W'(`BEV_AMOUNT_MAX) :
                                                     `BEV_AMOUNT_W'(total);
            amt[i]    = have[i];
        end
        e.err   = bev_pkg::err_none;
        e.write = 1'b0;
        e.rec   = r;
        case (c.action)
            bev_pkg::act_make_drink: begin
                if (late) begin
                    e.err = bev_pkg::err_expired;
                end else if (short_any) begin
                    e.err = bev_pkg::err_shortage;
                end else begin
                    e.write = 1'b1;
                    amt     = left;
                end
            end
            bev_pkg::act_supply: begin
                e.write     = 1'b1;
                amt         = sums;
                e.err       = over_any ? bev_pkg::err_overflow : bev_pkg::err_none;
                e.rec.month = 8'(c.date.month);
                e.rec.day   = 8'(c.date.day);
            end
            bev_pkg::act_check_date: begin
                e.err = late ? bev_pkg::err_expired : bev_pkg::err_none;
            end
            default: begin
                e.err = bev_pkg::err_none;
            end
        endcase
        e.rec.black_tea = amt[0];
        e.rec.green_tea = amt[1];
        e.rec.milk      = amt[2];
        e.rec.pineapple = amt[3];
        return e;
    endfunction

    task automatic flag_error(input string msg);
        $display("error at time %0d ns: %s", $time, msg);
        error_count = error_count + 1;
    endtask

    task automatic report_counts();
        $display("summary: %0d commands, %0d results, %0d memory requests, %0d errors",
                 cmd_count, result_count, req_count, error_count);
    endtask

    always @(posedge clk or negedge inf) begin
        if (!inf) begin
            for (int i = 0; i < (1 << `BEV_BOX_AW); i++) begin
                shadow[i] <= initial_record(`BEV_BOX_AW'(i));
            end
            expected     <= '0;
            box_q        <= '0;
            busy         <= 1'b0;
            req_seen     <= 0;
            cycle        <= 0;
            last_resp    <= 0;
            cmd_count    <= 0;
            req_count    <= 0;
            result_count <= 0;
            error_count = 0;
        end else begin
            cycle <= cycle + 1;
            if (cmd_valid) begin
                expected  <= predict(cmd, shadow[cmd.box]);
                box_q     <= cmd.box;
                busy      <= 1'b1;
                req_seen  <= 0;
                cmd_count <= cmd_count + 1;
            end
            if (mem_req_valid) begin
                req_count <= req_count + 1;
                req_seen  <= req_seen + 1;
                if (!busy) begin
                    flag_error("memory request with no command in flight");
                end
                if (mem_req.addr != box_q) begin
                    flag_error($sformatf("request to box %0d, command box %0d",
                                         mem_req.addr, box_q));
                end
                if (req_seen == 0) begin
                    if (mem_req.write) begin
                        flag_error("first request of a command is a write");
                    end
                end else if (req_seen == 1 && expected.write) begin
                    if (!mem_req.write) begin
                        flag_error("second request of a command is not a write");
                    end else if (mem_req.data != expected.rec) begin
                        flag_error($sformatf("write data %h, expected %h",
                                             mem_req.data, expected.rec));
                    end
                end else begin
                    flag_error("unexpected extra memory request");
                end
            end
            if (mem_resp_valid) begin
                last_resp <= cycle;
            end
            if (out_valid) begin
                if (!busy) begin
                    flag_error("result pulse with no command in flight");
                end else begin
                    // result follows the last memory response by 2 cycles
                    if (cycle != last_resp + 2) begin
                        flag_error($sformatf("result %0d cycles after last memory response",
                                             cycle - last_resp));
                    end
                    if (result.err != expected.err) begin
                        flag_error($sformatf("error code %0d, expected %0d",
                                             result.err, expected.err));
                    end
                    if (result.complete != (expected.err == bev_pkg::err_none)) begin
                        flag_error($sformatf("complete bit %0b with error code %0d",
                                             result.complete, expected.err));
                    end
                    if (req_seen != (expected.write ? 2 : 1)) begin
                        flag_error($sformatf("%0d memory requests for one command", req_seen));
                    end
                    if (expected.write) begin
                        shadow[box_q] <= expected.rec;
                    end
                end
                busy         <= 1'b0;
                result_count <= result_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_bev.sv
`default_nettype none

`include "bev_config.svh"

module tb_bev;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_COMMANDS   = 200;
    // 200 commands at 20 cycles each, plus reset and margin
    localparam int TIMEOUT_CYCLES = 4100;

    logic                   clk;
    logic                   inf;
    logic                   cmd_valid;
    bev_pkg::bev_cmd_t      cmd;
    logic                   mem_req_valid;
    bev_pkg::mem_req_t      mem_req;
    logic                   mem_resp_valid = 1'b0;
    bev_pkg::box_record_t   mem_resp_data  = '0;
    logic                   out_valid;
    bev_pkg::bev_result_t   result;

    int error_count;
    int result_count;
    int cycles   = 0;
    int cmd_seed = 61681;
    int lat_seed = 61681;

    // behavioral memory with one record per box
    bev_pkg::box_record_t   mem [1 << `BEV_BOX_AW];
    logic                   pending;
    logic [2:0]             wait_left;
    logic [`BEV_BOX_AW-1:0] resp_addr;

    bev_top DUT (
        .clk            (clk),
        .inf            (inf),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .out_valid      (out_valid),
        .result         (result)
    );

    bev_checker u_checker (
        .clk            (clk),
        .inf            (inf),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .out_valid      (out_valid),
        .result         (result),
        .error_count    (error_count),
        .result_count   (result_count)
    );

    // starting contents of a box, the checker fills its shadow the same way
    function automatic bev_pkg::box_record_t initial_record(input logic [`BEV_BOX_AW-1:0] a);
        bev_pkg::box_record_t w;
        int                   n;
        n           = int'(a);
        w.black_tea = `BEV_AMOUNT_W'((n * 149 + 211) % 4096);
        w.green_tea = `BEV_AMOUNT_W'((n * 83 + 1500) % 4096);
        w.milk      = `BEV_AMOUNT_W'((n * 197 + 37) % 4096);
        w.pineapple = `BEV_AMOUNT_W'((n * 59 + 2900) % 4096);
        w.month     = 8'(n % 12 + 1);
        w.day       = 8'((n * 7) % 28 + 1);
        return w;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles with %0d results", cycles, result_count);
            $display("Some tests failed");
            $finish;
        end
    end

    // one response per request after 1 to 4 cycles
    always @(posedge clk or negedge inf) begin
        logic [31:0] draw;
        if (!inf) begin
            for (int i = 0; i < (1 << `BEV_BOX_AW); i++) begin
                mem[i] <= initial_record(`BEV_BOX_AW'(i));
            end
            mem_resp_valid <= 1'b0;
            mem_resp_data  <= '0;
            pending        <= 1'b0;
            wait_left      <= 3'd0;
            resp_addr      <= '0;
        end else begin
            mem_resp_valid <= 1'b0;
            if (mem_req_valid) begin
                draw      = $random(lat_seed);
                resp_addr <= mem_req.addr;
                if (mem_req.write) begin
                    mem[mem_req.addr] <= mem_req.data;
                end
                if (draw[1:0] == 2'd0) begin
                    mem_resp_valid <= 1'b1;
                    mem_resp_data  <= mem[mem_req.addr];
                end else begin
                    pending   <= 1'b1;
                    wait_left <= {1'b0, draw[1:0]};
                end
            end else if (pending) begin
                if (wait_left == 3'd1) begin
                    mem_resp_valid <= 1'b1;
                    mem_resp_data  <= mem[resp_addr];
                    pending        <= 1'b0;
                end else begin
                    wait_left <= wait_left - 3'd1;
                end
            end
        end
    end

    // one random command, held for a single cycle
    task automatic send_command();
        bev_pkg::bev_cmd_t c;
        logic [31:0]       r;
        logic [31:0]       s;
        logic [31:0]       t;
        r = $random(cmd_seed);
        s = $random(cmd_seed);
        t = $random(cmd_seed);
        c = '0;
        if (r[2:0] < 3'd4) begin
            c.action = bev_pkg::act_make_drink;
        end else if (r[2:0] < 3'd6) begin
            c.action = bev_pkg::act_supply;
        end else begin
            c.action = bev_pkg::act_check_date;
        end
        c.drink      = bev_pkg::drink_e'(r[5:3]);
        c.size       = (r[7:6] == 2'd2) ? bev_pkg::size_s : bev_pkg::size_e'(r[7:6]);
        c.date.month = r[11:8] % 4'd12 + 4'd1;
        c.date.day   = r[16:12] % 5'd31 + 5'd1;
        // a small set of boxes so that commands act on each other's stock
        c.box        = {3'b0, r[21:17]};
        c.supply     = {s[11:0], s[23:12], t[11:0], t[23:12]};
        if (!r[22]) begin
            c.supply = c.supply & {4{12'h3ff}};
        end
        cmd       <= c;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    initial begin
        inf       = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        repeat (5) @(posedge clk);
        inf <= 1'b1;
        @(posedge clk);
        for (int n = 0; n < NUM_COMMANDS; n++) begin
            send_command();
            do begin
                @(posedge clk);
            end while (!out_valid);
        end
        repeat (4) @(posedge clk);
        u_checker.report_counts();
        if (error_count == 0 && result_count == NUM_COMMANDS) begin
            $display("All tests passed");
        end else begin
            if (result_count != NUM_COMMANDS) begin
                $display("expected %0d results but saw %0d", NUM_COMMANDS, result_count);
            end
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
